// ==== verilog/analogizer_consts.svh ====
/*
 * analogizer adapter constants
 * bridge page and offset of the settings word, settings field positions,
 * RGB to YPbPr matrix coefficients (1/256 units), chroma offset, DAC width
 */
`ifndef ANALOGIZER_CONSTS_SVH
`define ANALOGIZER_CONSTS_SVH

// settings word location on the bridge bus
`define ANLG_CFG_PAGE    8'hF7 // addr[31:24]
`define ANLG_CFG_OFFSET  4'h0  // addr[3:0]

// field positions inside the settings word
`define CONT_TYPE_MSB    4
`define CONT_TYPE_LSB    0
`define CONT_ASSIGN_MSB  9
`define CONT_ASSIGN_LSB  6
`define VIDEO_TYPE_MSB   13
`define VIDEO_TYPE_LSB   10
`define BLANK_SCREEN_BIT 14
`define OSD_BIT          15

// luma weights, sum is 256
`define COEF_Y_R   77
`define COEF_Y_G   150
`define COEF_Y_B   29
// blue difference
`define COEF_PB_R  (-43)
`define COEF_PB_G  (-85)
`define COEF_PB_B  128
// red difference
`define COEF_PR_R  128
`define COEF_PR_G  (-107)
`define COEF_PR_B  (-21)

`define CHROMA_OFFSET 128 // pb/pr midscale
`define DAC_BITS      6   // bits per channel on the video DAC

`endif

// ==== verilog/analogizer_pkg.sv ====
/*
 * shared types of the analogizer front end
 * pixel, timing, bridge request, settings fields, YPbPr and cartridge pins
 */
package analogizer_pkg;

	// one core pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// syncs are active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic csync;
		logic blank_n; // low during blanking
	} vid_timing_t;

	// analog output mode, other codes mean off
	typedef enum logic [3:0] {
		MODE_RGBS  = 4'd0,
		MODE_RGSB  = 4'd1, // sync on green
		MODE_YPBPR = 4'd2
	} video_mode_e;

	// bridge request, held stable by the master while req is high
	typedef struct packed {
		logic [31:0] addr;
		logic        wr;            // 1 write, 0 read
		logic [31:0] wdata;
		logic        little_endian; // 0 means bytes reversed
	} bridge_req_t;

	// decoded settings word, 15 bits
	typedef struct packed {
		logic [4:0]  cont_type;
		logic [3:0]  cont_assign;
		video_mode_e video_mode;
		logic        blank_screen;
		logic        osd;
	} settings_t;

	typedef struct packed {
		logic [7:0] y;
		logic [7:0] pb;
		logic [7:0] pr;
	} ypbpr_t;

	// cartridge port values plus direction, 1 = output
	typedef struct packed {
		logic [7:0] bank3; // {r[5:0], hsync, vsync}
		logic [7:0] bank2; // {b[0], blank_n, g[5:0]}
		logic [4:0] bank1; // b[5:1]
		logic [2:0] dir;   // {bank3, bank2, bank1}
	} cart_pins_t;

endpackage

// ==== verilog/bridge_config_regs.sv ====
/*
 * bridge bus slave for the settings word
 * four-phase req/ack handshake, one access per request
 * page/offset decode, byte swap for big-endian masters
 */
`timescale 1ns/1ps
`include "analogizer_consts.svh"

module bridge_config_regs
	import analogizer_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_bridge_req,   // four-phase request
	input  bridge_req_t i_bridge,
	output logic        o_bridge_ack,
	output logic [31:0] o_bridge_rdata, // valid while ack high
	output logic [31:0] o_cfg_word      // settings word, little-endian order
);

	typedef enum logic {
		ST_IDLE, // waiting for req
		ST_ACK   // access done, ack high until req drops
	} bridge_state_e;

	bridge_state_e state;
	logic          access;   // request seen in idle
	logic          addr_hit; // page and offset match

	// reverse byte order unless the master is little-endian
	function automatic logic [31:0] order_bytes(input logic [31:0] w, input logic le);
		logic [31:0] swapped;
		swapped = {w[7:0], w[15:8], w[23:16], w[31:24]};
		return le ? w : swapped;
	endfunction

	assign access   = (state == ST_IDLE) && i_bridge_req;
	assign addr_hit = (i_bridge.addr[31:24] == `ANLG_CFG_PAGE) &&
	                  (i_bridge.addr[3:0] == `ANLG_CFG_OFFSET);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state      <= ST_IDLE;
			o_cfg_word <= '0; // mode RGBS after reset
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_bridge_req) begin
						state <= ST_ACK; // ack visible next cycle
						if (i_bridge.wr && addr_hit) begin
							o_cfg_word <= order_bytes(i_bridge.wdata, i_bridge.little_endian);
						end
					end
				end
				ST_ACK: begin
					if (!i_bridge_req) state <= ST_IDLE; // ack drops a cycle after req
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read data captured with the access, zero on miss or write
	always_ff @(posedge i_clk) begin
		if (access) begin
			o_bridge_rdata <= (!i_bridge.wr && addr_hit) ?
			                  order_bytes(o_cfg_word, i_bridge.little_endian) : 32'h0;
		end
	end

	assign o_bridge_ack = (state == ST_ACK);

	// a new request only starts once the previous ack has dropped
	a_req_after_ack_low: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		$rose(i_bridge_req) |-> !o_bridge_ack
	) else $error("bridge req rose while ack still high");

endmodule

// ==== verilog/settings_decode.sv ====
/*
 * settings word field decode
 * one register stage from the word to the settings fields
 */
`timescale 1ns/1ps
`include "analogizer_consts.svh"

module settings_decode (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic [31:0]            i_cfg_word, // from the bridge register
	output analogizer_pkg::settings_t o_settings
);

	logic [3:0] video_type; // raw mode code, may be out of range

	assign video_type = i_cfg_word[`VIDEO_TYPE_MSB:`VIDEO_TYPE_LSB];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_settings <= '0; // all fields clear, RGBS
		end else begin
			o_settings.cont_type    <= i_cfg_word[`CONT_TYPE_MSB:`CONT_TYPE_LSB];
			o_settings.cont_assign  <= i_cfg_word[`CONT_ASSIGN_MSB:`CONT_ASSIGN_LSB];
			// codes above YPbPr pass through, the pin stage blacks them out
			o_settings.video_mode   <= analogizer_pkg::video_mode_e'(video_type);
			o_settings.blank_screen <= i_cfg_word[`BLANK_SCREEN_BIT];
			o_settings.osd          <= i_cfg_word[`OSD_BIT]; // osd request to the core
		end
	end

	// bit 5 and bits 31..16 are spare in this word

endmodule

// ==== verilog/ypbpr_matrix.sv ====
/*
 * two-stage RGB to YPbPr colour matrix
 * stage 1 blank mask and weighted sums, stage 2 scale, offset, clamp
 * masked rgb and timing follow the same pixel through both stages
 */
`timescale 1ns/1ps
`include "analogizer_consts.svh"

module ypbpr_matrix
	import analogizer_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  rgb_t        i_rgb,
	input  vid_timing_t i_timing,
	output ypbpr_t      o_ypbpr,
	output rgb_t        o_rgb,   // masked rgb, same latency as o_ypbpr
	output vid_timing_t o_timing
);

	localparam logic signed [17:0] K_Y_R  = `COEF_Y_R;
	localparam logic signed [17:0] K_Y_G  = `COEF_Y_G;
	localparam logic signed [17:0] K_Y_B  = `COEF_Y_B;
	localparam logic signed [17:0] K_PB_R = `COEF_PB_R;
	localparam logic signed [17:0] K_PB_G = `COEF_PB_G;
	localparam logic signed [17:0] K_PB_B = `COEF_PB_B;
	localparam logic signed [17:0] K_PR_R = `COEF_PR_R;
	localparam logic signed [17:0] K_PR_G = `COEF_PR_G;
	localparam logic signed [17:0] K_PR_B = `COEF_PR_B;
	localparam logic signed [17:0] K_OFS  = `CHROMA_OFFSET;

	rgb_t                rgb_mask;                 // blanked pixels forced black
	rgb_t                rgb_s1;
	vid_timing_t         tim_s1;
	logic signed [17:0]  y_sum, pb_sum, pr_sum;    // x256 sums
	logic signed [17:0]  y_scl, pb_scl, pr_scl;    // back to 8 bit range

	// weighted sum of one pixel, channels are unsigned
	function automatic logic signed [17:0] wsum(input rgb_t c, input logic signed [17:0] kr,
	                                            input logic signed [17:0] kg,
	                                            input logic signed [17:0] kb);
		return kr * $signed({10'd0, c.r}) + kg * $signed({10'd0, c.g}) +
		       kb * $signed({10'd0, c.b});
	endfunction

	// clamp to 0..255
	function automatic logic [7:0] sat8(input logic signed [17:0] v);
		if (v < 0) return 8'd0;
		if (v > 18'sd255) return 8'hFF;
		return v[7:0];
	endfunction

	assign rgb_mask = i_timing.blank_n ? i_rgb : '0;

	// stage 1
	always_ff @(posedge i_clk) begin
		y_sum  <= wsum(rgb_mask, K_Y_R, K_Y_G, K_Y_B);
		pb_sum <= wsum(rgb_mask, K_PB_R, K_PB_G, K_PB_B);
		pr_sum <= wsum(rgb_mask, K_PR_R, K_PR_G, K_PR_B);
		rgb_s1 <= rgb_mask;
	end

	assign y_scl  = y_sum >>> 8;
	assign pb_scl = (pb_sum >>> 8) + K_OFS; // arithmetic shift keeps the sign
	assign pr_scl = (pr_sum >>> 8) + K_OFS;

	// stage 2
	always_ff @(posedge i_clk) begin
		o_ypbpr.y  <= sat8(y_scl);
		o_ypbpr.pb <= sat8(pb_scl);
		o_ypbpr.pr <= sat8(pr_scl);
		o_rgb      <= rgb_s1;
	end

	// timing bits delayed to match
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tim_s1   <= '0;
			o_timing <= '0;
		end else begin
			tim_s1   <= i_timing;
			o_timing <= tim_s1;
		end
	end

endmodule

// ==== verilog/cart_video_out.sv ====
/*
 * analog mode select and cartridge pin packing
 * RGBS, RGsB, YPbPr or off, one register stage to the pins
 * pins and direction bits low while the adapter is disabled
 */
`timescale 1ns/1ps
`include "analogizer_consts.svh"

module cart_video_out
	import analogizer_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_ena,      // adapter enable
	input  settings_t   i_settings,
	input  ypbpr_t      i_ypbpr,
	input  rgb_t        i_rgb,      // already blank masked
	input  vid_timing_t i_timing,
	output cart_pins_t  o_pins
);

	logic [`DAC_BITS-1:0] dac_r, dac_g, dac_b; // values on the DAC inputs
	logic                 dac_hs, dac_vs;      // DAC sync pins
	logic                 dac_blank_n;
	cart_pins_t           pins_next;

	always_comb begin
		case (i_settings.video_mode)
			MODE_RGBS: begin
				dac_r       = i_rgb.r[7 -: `DAC_BITS];
				dac_g       = i_rgb.g[7 -: `DAC_BITS];
				dac_b       = i_rgb.b[7 -: `DAC_BITS];
				dac_hs      = i_timing.csync; // composite sync on the hsync pin
				dac_vs      = 1'b1;
				dac_blank_n = i_timing.blank_n;
			end
			MODE_RGSB: begin
				dac_r       = i_rgb.r[7 -: `DAC_BITS];
				dac_g       = i_rgb.g[7 -: `DAC_BITS];
				dac_b       = i_rgb.b[7 -: `DAC_BITS];
				dac_hs      = 1'b1;
				dac_vs      = i_timing.csync; // to DAC sync, ends up on green
				dac_blank_n = i_timing.blank_n;
			end
			MODE_YPBPR: begin
				dac_r       = i_ypbpr.pr[7 -: `DAC_BITS]; // Pr on red
				dac_g       = i_ypbpr.y[7 -: `DAC_BITS];  // Y on green
				dac_b       = i_ypbpr.pb[7 -: `DAC_BITS]; // Pb on blue
				dac_hs      = 1'b1;
				dac_vs      = i_timing.csync;
				dac_blank_n = 1'b1; // DAC blank must stay off, black comes from the matrix
			end
			default: begin
				// unknown mode, black with plain hsync
				dac_r       = '0;
				dac_g       = '0;
				dac_b       = '0;
				dac_hs      = i_timing.hsync;
				dac_vs      = 1'b1;
				dac_blank_n = i_timing.blank_n;
			end
		endcase
	end

	always_comb begin
		pins_next.bank3 = {dac_r, dac_hs, dac_vs};
		pins_next.bank2 = {dac_b[0], dac_blank_n, dac_g};
		pins_next.bank1 = dac_b[`DAC_BITS-1:1];
		pins_next.dir   = 3'b111; // all three banks drive
	end

	// output register, cleared in reset and while disabled
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pins <= '0;
		end else if (!i_ena) begin
			o_pins <= '0; // pins released to input
		end else begin
			o_pins <= pins_next;
		end
	end

	// rgb from the matrix is black whenever its aligned timing says blanking
	a_rgb_black_in_blank: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		!i_timing.blank_n |-> (i_rgb == '0)
	) else $error("rgb not black during blanking");

endmodule

// ==== verilog/analogizer_top.sv ====
/*
 * analogizer front end top level
 * bridge settings register, field decode, colour matrix, pin stage
 */
`timescale 1ns/1ps

module analogizer_top
	import analogizer_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_ena,
	input  logic        i_bridge_req,
	input  bridge_req_t i_bridge,
	input  rgb_t        i_rgb,
	input  vid_timing_t i_timing,
	output logic        o_bridge_ack,
	output logic [31:0] o_bridge_rdata,
	output settings_t   o_settings,
	output cart_pins_t  o_pins
);

	logic [31:0] cfg_word;   // raw settings word
	ypbpr_t      mtx_ypbpr;
	rgb_t        mtx_rgb;    // masked rgb, matrix latency
	vid_timing_t mtx_timing;

	bridge_config_regs u_bridge_config_regs (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_bridge_req   (i_bridge_req),
		.i_bridge       (i_bridge),
		.o_bridge_ack   (o_bridge_ack),
		.o_bridge_rdata (o_bridge_rdata),
		.o_cfg_word     (cfg_word)
	);

	settings_decode u_settings_decode (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_cfg_word (cfg_word),
		.o_settings (o_settings)
	);

	ypbpr_matrix u_ypbpr_matrix (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_rgb    (i_rgb),
		.i_timing (i_timing),
		.o_ypbpr  (mtx_ypbpr),
		.o_rgb    (mtx_rgb),
		.o_timing (mtx_timing)
	);

	cart_video_out u_cart_video_out (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_ena      (i_ena),
		.i_settings (o_settings),
		.i_ypbpr    (mtx_ypbpr),
		.i_rgb      (mtx_rgb),
		.i_timing   (mtx_timing),
		.o_pins     (o_pins)
	);

endmodule

// ==== testbench/tb_analogizer.sv ====
/*
 * testbench for the analogizer front end
 * clock, reset, DUT, bridge transfer tasks, pin and settings models
 * directed tests for reset, endian readback, address miss, modes, disable
 */
`timescale 1ns/1ps
`include "analogizer_consts.svh"

module tb_analogizer
	import analogizer_pkg::*;
();

	logic        i_clk;
	logic        i_arst_n;
	logic        i_ena;
	logic        i_bridge_req;
	bridge_req_t i_bridge;
	rgb_t        i_rgb;
	vid_timing_t i_timing;
	logic        o_bridge_ack;
	logic [31:0] o_bridge_rdata;
	settings_t   o_settings;
	cart_pins_t  o_pins;

	int check_errors;   // wrong values
	int timeout_errors; // handshakes that never completed

	analogizer_top u_analogizer_top (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_ena          (i_ena),
		.i_bridge_req   (i_bridge_req),
		.i_bridge       (i_bridge),
		.i_rgb          (i_rgb),
		.i_timing       (i_timing),
		.o_bridge_ack   (o_bridge_ack),
		.o_bridge_rdata (o_bridge_rdata),
		.o_settings     (o_settings),
		.o_pins         (o_pins)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk; // 100 ns period
	end

	// one cycle, inputs change 5 ns after the edge
	task automatic step();
		@(posedge i_clk);
		#5;
	endtask

	function automatic logic [31:0] cfg_addr(input logic [7:0] page, input logic [3:0] ofs);
		return {page, 20'h0, ofs}; // middle bits unused by the decode
	endfunction

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// settings fields as laid out in the word
	function automatic settings_t settings_of(input logic [31:0] w);
		settings_t s;
		s.cont_type    = w[`CONT_TYPE_MSB:`CONT_TYPE_LSB];
		s.cont_assign  = w[`CONT_ASSIGN_MSB:`CONT_ASSIGN_LSB];
		s.video_mode   = video_mode_e'(w[`VIDEO_TYPE_MSB:`VIDEO_TYPE_LSB]);
		s.blank_screen = w[`BLANK_SCREEN_BIT];
		s.osd          = w[`OSD_BIT];
		return s;
	endfunction

	function automatic logic [7:0] clamp8(input int v);
		if (v < 0) return 8'd0;
		if (v > 255) return 8'd255;
		return v[7:0];
	endfunction

	// expected pins for one pixel, from the matrix equations and the mode table
	function automatic cart_pins_t model_pins(input rgb_t px, input vid_timing_t t,
	                                          input logic [3:0] mode, input logic ena);
		cart_pins_t p;
		rgb_t       m;
		logic [7:0] y, pb, pr;
		logic [5:0] r6, g6, b6;
		logic       hs, vs, bn;
		m  = t.blank_n ? px : '0; // black during blanking
		y  = clamp8((`COEF_Y_R * int'(m.r) + `COEF_Y_G * int'(m.g) +
		             `COEF_Y_B * int'(m.b)) >>> 8);
		pb = clamp8(((`COEF_PB_R * int'(m.r) + `COEF_PB_G * int'(m.g) +
		              `COEF_PB_B * int'(m.b)) >>> 8) + `CHROMA_OFFSET);
		pr = clamp8(((`COEF_PR_R * int'(m.r) + `COEF_PR_G * int'(m.g) +
		              `COEF_PR_B * int'(m.b)) >>> 8) + `CHROMA_OFFSET);
		r6 = m.r[7:2];
		g6 = m.g[7:2];
		b6 = m.b[7:2];
		bn = t.blank_n;
		case (mode)
			4'd0: begin
				hs = t.csync; // RGBS
				vs = 1'b1;
			end
			4'd1: begin
				hs = 1'b1; // sync on green
				vs = t.csync;
			end
			4'd2: begin
				r6 = pr[7:2];
				g6 = y[7:2];
				b6 = pb[7:2];
				hs = 1'b1;
				vs = t.csync;
				bn = 1'b1;
			end
			default: begin
				r6 = '0; // off, black with raw hsync
				g6 = '0;
				b6 = '0;
				hs = t.hsync;
				vs = 1'b1;
			end
		endcase
		p.bank3 = {r6, hs, vs};
		p.bank2 = {b6[0], bn, g6};
		p.bank1 = b6[5:1];
		p.dir   = 3'b111;
		if (!ena) p = '0; // released
		return p;
	endfunction

	task automatic check_settings(input string name, input settings_t exp_v,
	                              input settings_t act_v);
		if (exp_v !== act_v) begin
			$display("CHECK FAILED at %0t ns: %s expected %h actual %h",
			         $time, name, exp_v, act_v);
			check_errors++;
		end
	endtask

	task automatic check_pins(input string name, input cart_pins_t exp_v,
	                          input cart_pins_t act_v);
		if (exp_v !== act_v) begin
			$display("CHECK FAILED at %0t ns: %s expected %h actual %h",
			         $time, name, exp_v, act_v);
			check_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp_v,
	                          input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("CHECK FAILED at %0t ns: %s expected %h actual %h",
			         $time, name, exp_v, act_v);
			check_errors++;
		end
	endtask

	// wait for ack to reach a level, 20 cycle limit
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_bridge_ack !== level && n < 20) begin
			step();
			n++;
		end
		if (o_bridge_ack !== level) begin
			$display("timeout at %0t ns: bridge ack did not go to %0d in 20 cycles",
			         $time, level);
			timeout_errors++;
		end
	endtask

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data,
	                            input logic le);
		i_bridge.addr          = addr;
		i_bridge.wr            = 1'b1;
		i_bridge.wdata         = data;
		i_bridge.little_endian = le;
		i_bridge_req           = 1'b1;
		wait_ack(1'b1);
		i_bridge_req = 1'b0;
		wait_ack(1'b0); // returns one cycle after ack rose
	endtask

	task automatic bridge_read(input logic [31:0] addr, input logic le,
	                           output logic [31:0] data);
		i_bridge.addr          = addr;
		i_bridge.wr            = 1'b0;
		i_bridge.wdata         = 32'h0;
		i_bridge.little_endian = le;
		i_bridge_req           = 1'b1;
		wait_ack(1'b1);
		data         = o_bridge_rdata; // valid while ack high
		i_bridge_req = 1'b0;
		wait_ack(1'b0);
	endtask

	// back to back random pixels, each checked 3 cycles after it was driven
	task automatic send_pixels(input int n, input logic [3:0] mode);
		cart_pins_t  exp_q[$];
		logic [31:0] rnd;
		int          i;
		for (i = 0; i < n + 3; i++) begin
			if (i >= 3) check_pins("o_pins", exp_q.pop_front(), o_pins);
			if (i < n) begin
				rnd      = $urandom();
				i_rgb    = rnd[23:0];
				i_timing = rnd[27:24]; // blanked pixels included
				exp_q.push_back(model_pins(i_rgb, i_timing, mode, i_ena));
			end
			step();
		end
	endtask

	task automatic test_reset_defaults();
		logic [31:0] rd;
		check_settings("o_settings", '0, o_settings);
		send_pixels(8, 4'd0); // RGBS after reset
		bridge_read(cfg_addr(`ANLG_CFG_PAGE, `ANLG_CFG_OFFSET), 1'b1, rd);
		check_word("o_bridge_rdata", 32'h0, rd);
	endtask

	task automatic test_endian_readback();
		logic [31:0] addr, w, rd;
		addr = cfg_addr(`ANLG_CFG_PAGE, `ANLG_CFG_OFFSET);
		w    = 32'h1234_C6D5; // mode RGsB
		bridge_write(addr, w, 1'b1);
		check_settings("o_settings", settings_of(w), o_settings);
		bridge_read(addr, 1'b1, rd);
		check_word("o_bridge_rdata le", w, rd);
		bridge_read(addr, 1'b0, rd);
		check_word("o_bridge_rdata be", swap_bytes(w), rd);
		w = 32'hC0DE_0A87; // big-endian master sends it byte reversed
		bridge_write(addr, swap_bytes(w), 1'b0);
		check_settings("o_settings", settings_of(w), o_settings);
		bridge_read(addr, 1'b1, rd);
		check_word("o_bridge_rdata le", w, rd);
	endtask

	task automatic test_address_miss();
		logic [31:0] addr, w, rd;
		addr = cfg_addr(`ANLG_CFG_PAGE, `ANLG_CFG_OFFSET);
		w    = 32'h0000_0400;
		bridge_write(addr, w, 1'b1);
		bridge_write(cfg_addr(8'hF6, `ANLG_CFG_OFFSET), 32'hFFFF_FFFF, 1'b1); // wrong page
		bridge_write(cfg_addr(`ANLG_CFG_PAGE, 4'h4), 32'hFFFF_FFFF, 1'b1);   // wrong offset
		check_settings("o_settings", settings_of(w), o_settings);
		bridge_read(cfg_addr(8'hF6, `ANLG_CFG_OFFSET), 1'b1, rd);
		check_word("o_bridge_rdata miss page", 32'h0, rd);
		bridge_read(cfg_addr(`ANLG_CFG_PAGE, 4'h4), 1'b0, rd);
		check_word("o_bridge_rdata miss offset", 32'h0, rd);
		bridge_read(addr, 1'b1, rd);
		check_word("o_bridge_rdata", w, rd);
	endtask

	task automatic test_stream_modes();
		logic [31:0] w;
		logic [3:0]  mode;
		for (int k = 1; k <= 2; k++) begin
			mode = k[3:0]; // RGsB then YPbPr
			w    = {16'h0, 2'b01, mode, 10'h0E2};
			bridge_write(cfg_addr(`ANLG_CFG_PAGE, `ANLG_CFG_OFFSET), w, 1'b1);
			check_settings("o_settings", settings_of(w), o_settings);
			send_pixels(40, mode);
		end
	endtask

	task automatic test_off_and_disable();
		logic [31:0] w;
		w = {16'h0, 2'b00, 4'd7, 10'h000}; // unknown mode code
		bridge_write(cfg_addr(`ANLG_CFG_PAGE, `ANLG_CFG_OFFSET), w, 1'b1);
		check_settings("o_settings", settings_of(w), o_settings);
		send_pixels(20, 4'd7);
		i_ena = 1'b0;
		step();
		check_pins("o_pins", '0, o_pins);
		send_pixels(10, 4'd7); // pins stay released
		i_ena = 1'b1;
		step();
	endtask

	initial begin
		void'($urandom(32'h9503));
		check_errors   = 0;
		timeout_errors = 0;
		i_arst_n       = 1'b0;
		i_ena          = 1'b1;
		i_bridge_req   = 1'b0;
		i_bridge       = '0;
		i_rgb          = '0;
		i_timing       = '0;
		repeat (4) @(posedge i_clk);
		#5;
		check_pins("o_pins", '0, o_pins); // still in reset
		check_word("o_bridge_ack", 32'h0, {31'h0, o_bridge_ack});
		i_arst_n = 1'b1;
		step();

		test_reset_defaults();
		if (timeout_errors == 0) test_endian_readback();
		if (timeout_errors == 0) test_address_miss();
		if (timeout_errors == 0) test_stream_modes();
		if (timeout_errors == 0) test_off_and_disable();

		$display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/analogizer_pkg.sv
verilog/bridge_config_regs.sv
verilog/settings_decode.sv
verilog/ypbpr_matrix.sv
verilog/cart_video_out.sv
verilog/analogizer_top.sv
testbench/tb_analogizer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the analogizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_analogizer \
	-Mdir obj_dir -o tb_analogizer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_analogizer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# pass only when the testbench printed its pass line
if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
